// File: csr_unit.f
+incdir+tests
verilog/csr_pkg.sv
verilog/csr_trap_if.sv
verilog/csr_file.sv
verilog/trap_ctrl.sv
verilog/clint_timer.sv
verilog/csr_unit.sv
tests/csr_unit_tb.sv

// File: tests/csr_unit_tests.svh
`ifndef CSR_UNIT_TESTS_SVH
`define CSR_UNIT_TESTS_SVH
`default_nettype none

task automatic drive_idle();
    inst_valid = 1'b0;
    csr_index = '0;
    csr_op = CSR_OP_NONE;
    rs1_data = '0;
    imm_csr = '0;
    inst_addr = '0;
    csr_src = 1'b0;
    inst_ecall = 1'b0;
    inst_ebreak = 1'b0;
    inst_mret = 1'b0;
    clint_we = 1'b0;
    clint_sel = 1'b0;
    clint_wdata = '0;
endtask

// read without retiring an instruction
task automatic read_csr(input csr_addr_t idx, output xlen_t val);
    @(negedge clk);
    drive_idle();
    csr_index = idx;
    #1 val = csr_read;
endtask

task automatic check_csr(input string name, input csr_addr_t idx, input xlen_t exp);
    xlen_t val;
    read_csr(idx, val);
    check_word(name, val, exp);
endtask

task automatic write_csr(input csr_addr_t idx, input csr_op_e op, input logic src,
                         input xlen_t data);
    @(negedge clk);
    drive_idle();
    inst_valid = 1'b1;
    csr_index = idx;
    csr_op = op;
    csr_src = src;
    if (src) begin
        imm_csr = data;
    end else begin
        rs1_data = data;
    end
endtask

task automatic clint_write(input logic sel, input xlen_t data);
    @(negedge clk);
    drive_idle();
    clint_we = 1'b1;
    clint_sel = sel;
    clint_wdata = data;
endtask

// one valid instruction, outputs sampled mid cycle
task automatic issue_inst(input logic ecall, input logic ebreak, input logic mret,
                          input xlen_t addr);
    @(negedge clk);
    drive_idle();
    inst_valid = 1'b1;
    inst_ecall = ecall;
    inst_ebreak = ebreak;
    inst_mret = mret;
    inst_addr = addr;
    #1;
endtask

task automatic reset_and_constants();
    check_bit("csr_trap", csr_trap, 1'b0);
    check_csr("mstatus", CSR_MSTATUS, '0);
    check_csr("mie", CSR_MIE, '0);
    check_csr("mtvec", CSR_MTVEC, '0);
    check_csr("mscratch", CSR_MSCRATCH, '0);
    check_csr("mepc", CSR_MEPC, '0);
    check_csr("mcause", CSR_MCAUSE, '0);
    check_csr("mip", CSR_MIP, '0);
    check_csr("misa", CSR_MISA, MISA_VALUE);
    check_csr("marchid", CSR_MARCHID, 64'd1);
    check_csr("mhartid", CSR_MHARTID, '0);
    check_csr("mvendorid", CSR_MVENDORID, '0);
    check_csr("mimpid", CSR_MIMPID, '0);
    // a plain valid instruction must not trap out of reset
    issue_inst(1'b0, 1'b0, 1'b0, '0);
    check_bit("csr_trap", csr_trap, 1'b0);
endtask

task automatic read_modify_write();
    xlen_t d;
    xlen_t exp;
    xlen_t raw;
    for (int src = 0; src < 2; src++) begin
        d = rand_word();
        write_csr(CSR_MSCRATCH, CSR_OP_RW, src[0], d);
        exp = d;
        check_csr("mscratch", CSR_MSCRATCH, exp);
        d = rand_word();
        write_csr(CSR_MSCRATCH, CSR_OP_RS, src[0], d);
        exp = exp | d;
        check_csr("mscratch", CSR_MSCRATCH, exp);
        d = rand_word();
        write_csr(CSR_MSCRATCH, CSR_OP_RC, src[0], d);
        exp = exp & ~d;
        check_csr("mscratch", CSR_MSCRATCH, exp);
    end
    raw = rand_word() | 64'h3;
    write_csr(CSR_MTVEC, CSR_OP_RW, 1'b0, raw);
    check_csr("mtvec", CSR_MTVEC, raw & ~64'h3);
    write_csr(CSR_MIE, CSR_OP_RW, 1'b0, '1);
    check_csr("mie", CSR_MIE, 64'h80);
    write_csr(CSR_MSTATUS, CSR_OP_RW, 1'b1, '1);
    check_csr("mstatus", CSR_MSTATUS, 64'h1888);
    // leave interrupts off for the trap tests
    write_csr(CSR_MIE, CSR_OP_RW, 1'b0, '0);
    write_csr(CSR_MSTATUS, CSR_OP_RW, 1'b0, '0);
    check_csr("mie", CSR_MIE, '0);
    check_csr("mstatus", CSR_MSTATUS, '0);
endtask

task automatic ecall_and_ebreak();
    xlen_t raw;
    xlen_t epc_a;
    xlen_t epc_b;
    raw = rand_word();
    trap_vec = raw & ~64'h3;
    epc_a = rand_word() & ~64'h3;
    epc_b = rand_word() & ~64'h3;
    write_csr(CSR_MTVEC, CSR_OP_RW, 1'b0, raw);
    write_csr(CSR_MSTATUS, CSR_OP_RW, 1'b0, 64'h8);

    issue_inst(1'b1, 1'b0, 1'b0, epc_a);
    check_bit("csr_trap", csr_trap, 1'b1);
    check_word("csr_nxt_pc", csr_nxt_pc, trap_vec);
    check_csr("mepc", CSR_MEPC, epc_a);
    check_csr("mcause", CSR_MCAUSE, 64'd11);
    check_csr("mstatus", CSR_MSTATUS, 64'h1880);

    issue_inst(1'b0, 1'b0, 1'b1, '0);
    check_bit("csr_trap", csr_trap, 1'b1);
    check_word("csr_nxt_pc", csr_nxt_pc, epc_a);
    check_csr("mstatus", CSR_MSTATUS, 64'h1888);

    // ebreak with MIE clear, so MPIE has to follow it
    write_csr(CSR_MSTATUS, CSR_OP_RC, 1'b0, 64'h8);
    issue_inst(1'b0, 1'b1, 1'b0, epc_b);
    check_bit("csr_trap", csr_trap, 1'b1);
    check_word("csr_nxt_pc", csr_nxt_pc, trap_vec);
    check_csr("mepc", CSR_MEPC, epc_b);
    check_csr("mcause", CSR_MCAUSE, 64'd3);
    check_csr("mstatus", CSR_MSTATUS, 64'h1800);

    issue_inst(1'b0, 1'b0, 1'b1, '0);
    check_bit("csr_trap", csr_trap, 1'b1);
    check_word("csr_nxt_pc", csr_nxt_pc, epc_b);
    check_csr("mstatus", CSR_MSTATUS, 64'h1880);
endtask

task automatic timer_interrupt();
    xlen_t pc;
    xlen_t val;
    logic  seen;
    seen = 1'b0;
    pc = '0;
    clint_write(1'b0, '0);
    clint_write(1'b1, 64'd20);
    write_csr(CSR_MIE, CSR_OP_RS, 1'b0, 64'h80);
    write_csr(CSR_MSTATUS, CSR_OP_RS, 1'b1, 64'h8);
    for (int cycles = 0; cycles < 200 && !seen; cycles++) begin
        pc = 64'h8000_0000 + 64'(cycles * 4);
        issue_inst(1'b0, 1'b0, 1'b0, pc);
        seen = csr_trap;
    end
    if (!seen) begin
        fail_now("timer interrupt did not raise csr_trap within 200 cycles");
    end
    check_word("csr_nxt_pc", csr_nxt_pc, trap_vec);
    check_csr("mcause", CSR_MCAUSE, CAUSE_MTIMER);
    check_csr("mepc", CSR_MEPC, pc);
    read_csr(CSR_MIP, val);
    check_bit("mip[7]", val[7], 1'b1);

    // interrupt still pending, so it wins over the ecall
    write_csr(CSR_MSTATUS, CSR_OP_RS, 1'b0, 64'h8);
    issue_inst(1'b1, 1'b0, 1'b0, 64'h8000_1000);
    check_bit("csr_trap", csr_trap, 1'b1);
    check_csr("mcause", CSR_MCAUSE, CAUSE_MTIMER);

    clint_write(1'b1, '1);
    write_csr(CSR_MIE, CSR_OP_RC, 1'b0, 64'h80);
    check_csr("mie", CSR_MIE, '0);
endtask

task automatic counters();
    xlen_t c0;
    xlen_t m0;
    xlen_t m1;
    xlen_t v;
    int    n;
    read_csr(CSR_MINSTRET, c0);
    n = int'(lcg_next() % 8) + 1;
    repeat (n) issue_inst(1'b0, 1'b0, 1'b0, '0);
    check_csr("minstret", CSR_MINSTRET, c0 + xlen_t'(n));
    read_csr(CSR_MCYCLE, m0);
    read_csr(CSR_MCYCLE, m1);
    check_word("mcycle", m1, m0 + 64'd1);
    v = rand_word();
    write_csr(CSR_MINSTRET, CSR_OP_RW, 1'b0, v);
    repeat (3) issue_inst(1'b0, 1'b0, 1'b0, '0);
    check_csr("minstret", CSR_MINSTRET, v + 64'd3);
endtask

`default_nettype wire
`endif

// File: tests/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    logic      clk;
    logic      rst;
    logic      inst_valid;
    csr_addr_t csr_index;
    csr_op_e   csr_op;
    xlen_t     rs1_data;
    xlen_t     imm_csr;
    xlen_t     inst_addr;
    logic      csr_src;
    logic      inst_ecall;
    logic      inst_ebreak;
    logic      inst_mret;
    logic      clint_we;
    logic      clint_sel;
    xlen_t     clint_wdata;
    logic      csr_trap;
    xlen_t     csr_nxt_pc;
    xlen_t     csr_read;

    logic [31:0] lcg_state = 32'had79;
    // mtvec as programmed by the trap tests
    xlen_t       trap_vec;

    csr_unit #(
        .TIMER_DIV (2)
    ) csr_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .csr_index   (csr_index),
        .csr_op      (csr_op),
        .rs1_data    (rs1_data),
        .imm_csr     (imm_csr),
        .inst_addr   (inst_addr),
        .csr_src     (csr_src),
        .inst_ecall  (inst_ecall),
        .inst_ebreak (inst_ebreak),
        .inst_mret   (inst_mret),
        .clint_we    (clint_we),
        .clint_sel   (clint_sel),
        .clint_wdata (clint_wdata),
        .csr_trap    (csr_trap),
        .csr_nxt_pc  (csr_nxt_pc),
        .csr_read    (csr_read)
    );

    always #2 clk = ~clk;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function xlen_t rand_word();
        xlen_t w;
        w[63:32] = lcg_next();
        w[31:0] = lcg_next();
        return w;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    `include "csr_unit_tests.svh"

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        drive_idle();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_and_constants();
        read_modify_write();
        ecall_and_ebreak();
        timer_interrupt();
        counters();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/clint_timer.sv
`default_nettype none

module clint_timer #(
    parameter int TIMER_DIV = 1
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   clint_we,
    input  wire                   clint_sel,
    input  wire csr_pkg::xlen_t   clint_wdata,
    output logic                  mtip
);
    import csr_pkg::*;

    localparam int PRE_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TIMER_DIV - 1);

    logic [PRE_W-1:0] pre_cnt;
    logic             tick;
    xlen_t            mtime;
    xlen_t            mtimecmp;

    assign tick = (pre_cnt == PRE_LAST);

    // writing mtime restarts the prescaler
    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt <= '0;
            mtime <= '0;
        end else if (clint_we && !clint_sel) begin
            pre_cnt <= '0;
            mtime <= clint_wdata;
        end else if (tick) begin
            pre_cnt <= '0;
            mtime <= mtime + 1'b1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // all ones keeps the interrupt off out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;
        end else if (clint_we && clint_sel) begin
            mtimecmp <= clint_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp);
        end
    end

endmodule

`default_nettype wire

// File: verilog/csr_file.sv
`default_nettype none

module csr_file (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       inst_valid,
    input  wire csr_pkg::csr_addr_t   csr_index,
    input  wire csr_pkg::csr_op_e     csr_op,
    input  wire csr_pkg::xlen_t       rs1_data,
    input  wire csr_pkg::xlen_t       imm_csr,
    input  wire                       csr_src,
    input  wire                       mtip,
    output csr_pkg::xlen_t            csr_read,
    csr_trap_if.csr_side              trap_bus
);
    import csr_pkg::*;

    xlen_t wr_src;
    xlen_t csr_old;
    xlen_t csr_nxt;
    logic  csr_we;

    xlen_t mstatus_r;
    xlen_t mtvec_r;
    xlen_t mepc_r;
    xlen_t mcause_r;
    xlen_t mip_r;
    xlen_t mie_r;
    xlen_t mscratch_r;
    xlen_t mcycle_r;
    xlen_t minstret_r;

    assign wr_src = csr_src ? imm_csr : rs1_data;

    // trap or mret on the same instruction drops the write
    assign csr_we = inst_valid && (csr_op != CSR_OP_NONE)
                    && !trap_bus.trap_en && !trap_bus.ret_en;

    always_comb begin
        case (csr_index)
            CSR_MSTATUS:   csr_old = mstatus_r;
            CSR_MISA:      csr_old = MISA_VALUE;
            CSR_MIE:       csr_old = mie_r;
            CSR_MTVEC:     csr_old = mtvec_r;
            CSR_MSCRATCH:  csr_old = mscratch_r;
            CSR_MEPC:      csr_old = mepc_r;
            CSR_MCAUSE:    csr_old = mcause_r;
            CSR_MIP:       csr_old = mip_r;
            CSR_MCYCLE:    csr_old = mcycle_r;
            CSR_MINSTRET:  csr_old = minstret_r;
            CSR_MARCHID:   csr_old = MARCHID_VALUE;
            // mvendorid, mimpid, mhartid and unknown indices
            default:       csr_old = '0;
        endcase
    end

    assign csr_read = csr_old;

    always_comb begin
        case (csr_op)
            CSR_OP_RW: csr_nxt = wr_src;
            CSR_OP_RS: csr_nxt = csr_old | wr_src;
            CSR_OP_RC: csr_nxt = csr_old & ~wr_src;
            default:   csr_nxt = csr_old;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_r <= '0;
        end else if (trap_bus.trap_en) begin
            mstatus_r[MSTATUS_MPP+1:MSTATUS_MPP] <= 2'b11;
            mstatus_r[MSTATUS_MPIE] <= mstatus_r[MSTATUS_MIE];
            mstatus_r[MSTATUS_MIE] <= 1'b0;
        end else if (trap_bus.ret_en) begin
            mstatus_r[MSTATUS_MIE] <= mstatus_r[MSTATUS_MPIE];
            mstatus_r[MSTATUS_MPIE] <= 1'b1;
        end else if (csr_we && csr_index == CSR_MSTATUS) begin
            mstatus_r <= csr_nxt & MSTATUS_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_r <= '0;
            mie_r <= '0;
            mscratch_r <= '0;
        end else if (csr_we) begin
            // direct mode only, base is word aligned
            if (csr_index == CSR_MTVEC) begin
                mtvec_r <= {csr_nxt[XLEN-1:2], 2'b00};
            end
            if (csr_index == CSR_MIE) begin
                mie_r <= csr_nxt & MIE_MASK;
            end
            if (csr_index == CSR_MSCRATCH) begin
                mscratch_r <= csr_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_r <= '0;
            mcause_r <= '0;
        end else if (trap_bus.trap_en) begin
            mepc_r <= trap_bus.epc;
            mcause_r <= trap_bus.cause;
        end else if (csr_we && csr_index == CSR_MEPC) begin
            mepc_r <= csr_nxt;
        end else if (csr_we && csr_index == CSR_MCAUSE) begin
            mcause_r <= csr_nxt;
        end
    end

    // pending timer bit sticks until software clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            mip_r <= '0;
        end else if (csr_we && csr_index == CSR_MIP) begin
            mip_r <= csr_nxt & MIE_MASK;
        end else if (mtip) begin
            mip_r[MTI_BIT] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_r <= '0;
        end else if (csr_we && csr_index == CSR_MCYCLE) begin
            mcycle_r <= csr_nxt;
        end else begin
            mcycle_r <= mcycle_r + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret_r <= '0;
        end else if (csr_we && csr_index == CSR_MINSTRET) begin
            minstret_r <= csr_nxt;
        end else if (inst_valid) begin
            minstret_r <= minstret_r + 1'b1;
        end
    end

    assign trap_bus.mtvec = mtvec_r;
    assign trap_bus.mepc = mepc_r;
    assign trap_bus.glob_ie = mstatus_r[MSTATUS_MIE];
    assign trap_bus.mtie = mie_r[MTI_BIT];

endmodule

`default_nettype wire

// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    parameter int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0]     csr_addr_t;

    typedef enum logic [1:0] {
        CSR_OP_NONE = 2'd0,
        CSR_OP_RW   = 2'd1,
        CSR_OP_RS   = 2'd2,
        CSR_OP_RC   = 2'd3
    } csr_op_e;

    // machine-mode CSR addresses
    parameter csr_addr_t CSR_MSTATUS   = 12'h300;
    parameter csr_addr_t CSR_MISA      = 12'h301;
    parameter csr_addr_t CSR_MIE       = 12'h304;
    parameter csr_addr_t CSR_MTVEC     = 12'h305;
    parameter csr_addr_t CSR_MSCRATCH  = 12'h340;
    parameter csr_addr_t CSR_MEPC      = 12'h341;
    parameter csr_addr_t CSR_MCAUSE    = 12'h342;
    parameter csr_addr_t CSR_MIP       = 12'h344;
    parameter csr_addr_t CSR_MCYCLE    = 12'hb00;
    parameter csr_addr_t CSR_MINSTRET  = 12'hb02;
    parameter csr_addr_t CSR_MVENDORID = 12'hf11;
    parameter csr_addr_t CSR_MARCHID   = 12'hf12;
    parameter csr_addr_t CSR_MIMPID    = 12'hf13;
    parameter csr_addr_t CSR_MHARTID   = 12'hf14;

    // writable bits
    parameter xlen_t MSTATUS_MASK = 64'h0000_0000_0000_1888;
    parameter xlen_t MIE_MASK     = 64'h0000_0000_0000_0080;

    // mstatus and mie/mip bit positions
    parameter int MSTATUS_MIE  = 3;
    parameter int MSTATUS_MPIE = 7;
    parameter int MSTATUS_MPP  = 11;
    parameter int MTI_BIT      = 7;

    parameter xlen_t CAUSE_ECALL  = 64'd11;
    parameter xlen_t CAUSE_EBREAK = 64'd3;
    parameter xlen_t CAUSE_MTIMER = {1'b1, 63'd7};

    // RV64I
    parameter xlen_t MISA_VALUE    = 64'h8000_0000_0000_0100;
    parameter xlen_t MARCHID_VALUE = 64'd1;

endpackage

`default_nettype wire

// File: verilog/csr_trap_if.sv
`default_nettype none

interface csr_trap_if;
    import csr_pkg::*;

    logic  trap_en;
    logic  ret_en;
    xlen_t cause;
    xlen_t epc;
    xlen_t mtvec;
    xlen_t mepc;
    logic  glob_ie;
    logic  mtie;

    modport trap_side (
        output trap_en,
        output ret_en,
        output cause,
        output epc,
        input  mtvec,
        input  mepc,
        input  glob_ie,
        input  mtie
    );

    modport csr_side (
        input  trap_en,
        input  ret_en,
        input  cause,
        input  epc,
        output mtvec,
        output mepc,
        output glob_ie,
        output mtie
    );

endinterface

`default_nettype wire

// File: verilog/csr_unit.sv
`default_nettype none

module csr_unit #(
    parameter int TIMER_DIV = 1
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       inst_valid,
    input  wire csr_pkg::csr_addr_t   csr_index,
    input  wire csr_pkg::csr_op_e     csr_op,
    input  wire csr_pkg::xlen_t       rs1_data,
    input  wire csr_pkg::xlen_t       imm_csr,
    input  wire csr_pkg::xlen_t       inst_addr,
    input  wire                       csr_src,
    input  wire                       inst_ecall,
    input  wire                       inst_ebreak,
    input  wire                       inst_mret,
    input  wire                       clint_we,
    input  wire                       clint_sel,
    input  wire csr_pkg::xlen_t       clint_wdata,
    output logic                      csr_trap,
    output csr_pkg::xlen_t            csr_nxt_pc,
    output csr_pkg::xlen_t            csr_read
);

    wire mtip;

    csr_trap_if trap_bus ();

    csr_file csr_file_inst (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .csr_index  (csr_index),
        .csr_op     (csr_op),
        .rs1_data   (rs1_data),
        .imm_csr    (imm_csr),
        .csr_src    (csr_src),
        .mtip       (mtip),
        .csr_read   (csr_read),
        .trap_bus   (trap_bus.csr_side)
    );

    trap_ctrl trap_ctrl_inst (
        .inst_valid  (inst_valid),
        .inst_ecall  (inst_ecall),
        .inst_ebreak (inst_ebreak),
        .inst_mret   (inst_mret),
        .inst_addr   (inst_addr),
        .mtip        (mtip),
        .csr_trap    (csr_trap),
        .csr_nxt_pc  (csr_nxt_pc),
        .trap_bus    (trap_bus.trap_side)
    );

    // timer interrupt feeds both mip and the trap logic
    clint_timer #(
        .TIMER_DIV (TIMER_DIV)
    ) clint_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .clint_we    (clint_we),
        .clint_sel   (clint_sel),
        .clint_wdata (clint_wdata),
        .mtip        (mtip)
    );

endmodule

`default_nettype wire

// File: verilog/trap_ctrl.sv
`default_nettype none

module trap_ctrl (
    input  wire                   inst_valid,
    input  wire                   inst_ecall,
    input  wire                   inst_ebreak,
    input  wire                   inst_mret,
    input  wire csr_pkg::xlen_t   inst_addr,
    input  wire                   mtip,
    output logic                  csr_trap,
    output csr_pkg::xlen_t        csr_nxt_pc,
    csr_trap_if.trap_side         trap_bus
);
    import csr_pkg::*;

    logic  irq_pending;
    logic  take_trap;
    logic  take_ret;
    xlen_t trap_cause;

    // timer interrupt is only seen when enabled globally and locally
    assign irq_pending = trap_bus.glob_ie && trap_bus.mtie && mtip;

    assign take_trap = inst_valid && (irq_pending || inst_ecall || inst_ebreak);

    // an mret hit by an interrupt is replaced by the trap
    assign take_ret = inst_valid && inst_mret && !take_trap;

    always_comb begin
        if (irq_pending) begin
            trap_cause = CAUSE_MTIMER;
        end else if (inst_ecall) begin
            trap_cause = CAUSE_ECALL;
        end else begin
            trap_cause = CAUSE_EBREAK;
        end
    end

    assign trap_bus.trap_en = take_trap;
    assign trap_bus.ret_en = take_ret;
    assign trap_bus.cause = trap_cause;
    assign trap_bus.epc = inst_addr;

    always_comb begin
        if (take_trap) begin
            csr_nxt_pc = trap_bus.mtvec;
        end else begin
            csr_nxt_pc = trap_bus.mepc;
        end
    end

    assign csr_trap = take_trap || take_ret;

endmodule

`default_nettype wire
